// File: design/cache_geom_pkg.sv
// Cache geometry constants and vector types for address fields, words, lines and ways.

package cache_geom_pkg;

    // ----------------------------------------
    // Geometry.
    // ----------------------------------------
    localparam int ADDR_W         = 32;
    localparam int SET_COUNT      = 16;
    localparam int WAYS           = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
    localparam int INDEX_W        = $clog2(SET_COUNT);
    localparam int WORD_OFF_W     = $clog2(WORDS_PER_LINE);
    localparam int BYTE_OFF_W     = $clog2(WORD_W / 8);
    localparam int TAG_W          = ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;
    localparam int LINE_BYTES     = LINE_W / 8;

    // ----------------------------------------
    // Field types.
    // ----------------------------------------
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_OFF_W-1:0] word_off_t;
    typedef logic [BYTE_OFF_W-1:0] byte_off_t;

    // Way number, also used as an LRU age.
    typedef logic [$clog2(WAYS)-1:0] way_t;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

endpackage

// File: design/cache_op_pkg.sv
// Store size encoding and per-line byte enable type.

package cache_op_pkg;

    // Store width requested by the controller.
    typedef enum logic [1:0] {
        STORE_BYTE = 2'd0,
        STORE_HALF = 2'd1,
        STORE_WORD = 2'd2
    } store_size_e;

    // One enable per byte of a cache line.
    typedef logic [cache_geom_pkg::LINE_BYTES-1:0] line_be_t;

endpackage

// File: design/cache_lookup_if.sv
// Lookup interface shared by the store aligner, tag array and data array.
`timescale 1ns/100ps

interface cache_lookup_if;
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    // Request fields and prepared store.
    index_t    index;
    tag_t      tag;
    word_off_t word_off;
    line_be_t  line_be;
    line_t     line_wdata;
    logic      store_ok;

    // Lookup results.
    way_t      hit_way;
    way_t      victim_way;
    logic      commit;

    modport align (output index, tag, word_off, line_be, line_wdata, store_ok);
    modport tags  (input index, tag, store_ok, output hit_way, victim_way, commit);
    modport data  (input index, word_off, line_be, line_wdata, hit_way, victim_way, commit);

endinterface

// File: design/store_align.sv
// Address split, store misalignment check, byte enables and lane replication.
`timescale 1ns/100ps

module store_align (
    input  cache_geom_pkg::addr_t     i_addr,
    input  cache_geom_pkg::word_t     i_wdata,
    input  cache_op_pkg::store_size_e i_store_size,
    input  logic                      i_write_en,
    output logic                      o_misaligned,
    cache_lookup_if.align             lk
);
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    byte_off_t  byte_off;
    logic [3:0] lane_mask;

    // Tag, set, word and byte fields from high to low.
    assign {lk.tag, lk.index, lk.word_off, byte_off} = i_addr;

    // ----------------------------------------
    // Size decode.
    // ----------------------------------------
    always_comb begin
        case (i_store_size)
            STORE_BYTE: begin
                o_misaligned  = 1'b0;
                lane_mask     = 4'b0001;
                lk.line_wdata = {LINE_BYTES{i_wdata[7:0]}};
            end
            STORE_HALF: begin
                o_misaligned  = byte_off[0];
                lane_mask     = 4'b0011;
                lk.line_wdata = {(LINE_BYTES / 2){i_wdata[15:0]}};
            end
            STORE_WORD: begin
                o_misaligned  = |byte_off;
                lane_mask     = 4'b1111;
                lk.line_wdata = {WORDS_PER_LINE{i_wdata}};
            end
            default: begin
                // Unused encoding, never stored.
                o_misaligned  = 1'b1;
                lane_mask     = '0;
                lk.line_wdata = '0;
            end
        endcase
    end

    // Enables start at byte word_off*4 + byte_off.
    assign lk.line_be  = line_be_t'(lane_mask) << {lk.word_off, byte_off};
    assign lk.store_ok = i_write_en & ~o_misaligned;

endmodule

// File: design/tag_lru_array.sv
// Tag, valid, dirty and LRU storage with hit detect, victim choice and writeback address.
`timescale 1ns/100ps

module tag_lru_array (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic                  i_write_en,
    input  logic                  i_refill_en,
    input  logic                  i_lru_update,
    output logic                  o_hit,
    output logic                  o_dirty,
    output cache_geom_pkg::addr_t o_wb_addr,
    cache_lookup_if.tags          lk
);
    import cache_geom_pkg::*;

    tag_t            tag_mem   [SET_COUNT][WAYS];
    logic [WAYS-1:0] valid_mem [SET_COUNT];
    logic [WAYS-1:0] dirty_mem [SET_COUNT];
    way_t            age_mem   [SET_COUNT][WAYS];

    logic [WAYS-1:0] hit_vec;
    logic [WAYS-1:0] victim_vec;

    // Lowest set bit to way number.
    function automatic way_t first_set(input logic [WAYS-1:0] vec);
        way_t w_idx;
        w_idx = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (vec[w]) begin
                w_idx = way_t'(w);
            end
        end
        return w_idx;
    endfunction

    // ----------------------------------------
    // Lookup.
    // ----------------------------------------
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w]    = valid_mem[lk.index][w] && (tag_mem[lk.index][w] == lk.tag);
            victim_vec[w] = (age_mem[lk.index][w] == '0);
        end
    end

    assign o_hit         = |hit_vec;
    assign lk.hit_way    = first_set(hit_vec);
    assign lk.victim_way = first_set(victim_vec);
    assign lk.commit     = lk.store_ok & o_hit;

    assign o_dirty   = dirty_mem[lk.index][lk.victim_way];
    assign o_wb_addr = {tag_mem[lk.index][lk.victim_way], lk.index,
                        {(WORD_OFF_W + BYTE_OFF_W){1'b0}}};

    // ----------------------------------------
    // State update.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_refill_en) begin
            tag_mem[lk.index][lk.victim_way] <= lk.tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
                // Way w starts with age w.
                for (int w = 0; w < WAYS; w++) begin
                    age_mem[s][w] <= way_t'(w);
                end
            end
        end else begin
            if (i_refill_en) begin
                valid_mem[lk.index][lk.victim_way] <= 1'b1;
                dirty_mem[lk.index][lk.victim_way] <= 1'b0;
            end else if (lk.commit) begin
                dirty_mem[lk.index][lk.hit_way] <= 1'b1;
            end

            // Touched way becomes newest and newer ways shift down.
            if (i_lru_update && o_hit) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (way_t'(w) == lk.hit_way) begin
                        age_mem[lk.index][w] <= way_t'(WAYS - 1);
                    end else if (age_mem[lk.index][w] > age_mem[lk.index][lk.hit_way]) begin
                        age_mem[lk.index][w] <= age_mem[lk.index][w] - way_t'(1);
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Checks.
    // ----------------------------------------
    a_write_refill_excl: assert property (
        @(posedge clk) disable iff (!arstn) !(i_write_en && i_refill_en)
    );

    a_single_hit: assert property (
        @(posedge clk) disable iff (!arstn) $onehot0(hit_vec)
    );

endmodule

// File: design/data_array.sv
// Line storage with byte-enabled stores, line refill and word read.
`timescale 1ns/100ps

module data_array (
    input  logic                  clk,
    input  logic                  i_refill_en,
    input  cache_geom_pkg::line_t i_refill_line,
    output cache_geom_pkg::word_t o_rdata,
    cache_lookup_if.data          lk
);
    import cache_geom_pkg::*;

    line_t data_mem [SET_COUNT][WAYS];
    line_t hit_line;

    // ----------------------------------------
    // Write path.
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (i_refill_en) begin
            data_mem[lk.index][lk.victim_way] <= i_refill_line;
        end else if (lk.commit) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (lk.line_be[b]) begin
                    data_mem[lk.index][lk.hit_way][b*8 +: 8] <= lk.line_wdata[b*8 +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Read path.
    // ----------------------------------------
    assign hit_line = data_mem[lk.index][lk.hit_way];
    assign o_rdata  = hit_line[lk.word_off*WORD_W +: WORD_W];

    // A committed store always touches at least one byte.
    a_commit_has_bytes: assert property (
        @(posedge clk) lk.commit |-> (|lk.line_be)
    );

endmodule

// File: design/data_cache.sv
// Top level of the 4-way set-associative data cache array.
`timescale 1ns/100ps

module data_cache (
    input  logic                      clk,
    input  logic                      arstn,
    input  cache_geom_pkg::addr_t     i_addr,
    input  cache_geom_pkg::word_t     i_wdata,
    input  cache_op_pkg::store_size_e i_store_size,
    input  logic                      i_write_en,
    input  logic                      i_refill_en,
    input  cache_geom_pkg::line_t     i_refill_line,
    input  logic                      i_lru_update,
    output logic                      o_hit,
    output cache_geom_pkg::word_t     o_rdata,
    output logic                      o_misaligned,
    output logic                      o_dirty,
    output cache_geom_pkg::addr_t     o_wb_addr
);

    cache_lookup_if lk ();

    store_align u_store_align (
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_store_size (i_store_size),
        .i_write_en   (i_write_en),
        .o_misaligned (o_misaligned),
        .lk           (lk)
    );

    tag_lru_array u_tag_lru_array (
        .clk          (clk),
        .arstn        (arstn),
        .i_write_en   (i_write_en),
        .i_refill_en  (i_refill_en),
        .i_lru_update (i_lru_update),
        .o_hit        (o_hit),
        .o_dirty      (o_dirty),
        .o_wb_addr    (o_wb_addr),
        .lk           (lk)
    );

    data_array u_data_array (
        .clk           (clk),
        .i_refill_en   (i_refill_en),
        .i_refill_line (i_refill_line),
        .o_rdata       (o_rdata),
        .lk            (lk)
    );

endmodule

// File: verif/tb_clkgen.sv
// Testbench clock and active-low reset generator.
`timescale 1ns/100ps

module tb_clkgen (
    output logic o_clk,
    output logic o_arstn
);
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD) o_clk = ~o_clk;
        end
    end

    // Release just after an edge, like the stimulus.
    initial begin
        o_arstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #2 o_arstn = 1'b1;
    end

endmodule

// File: verif/tb_data_cache.sv
// Testbench top with reference model, stimulus and output checks for the data cache.
`timescale 1ns/100ps

module tb_data_cache;
    import cache_geom_pkg::*;
    import cache_op_pkg::*;

    localparam int RESET_TIMEOUT = 20;

    logic        clk;
    logic        arstn;
    addr_t       i_addr;
    word_t       i_wdata;
    store_size_e i_store_size;
    logic        i_write_en;
    logic        i_refill_en;
    line_t       i_refill_line;
    logic        i_lru_update;
    logic        o_hit;
    word_t       o_rdata;
    logic        o_misaligned;
    logic        o_dirty;
    addr_t       o_wb_addr;

    // Reference model state.
    logic       m_valid [SET_COUNT][WAYS];
    logic       m_dirty [SET_COUNT][WAYS];
    tag_t       m_tag   [SET_COUNT][WAYS];
    int         m_age   [SET_COUNT][WAYS];
    logic [7:0] m_bytes [SET_COUNT][WAYS][LINE_BYTES];

    logic        exp_hit;
    logic        exp_misaligned;
    logic        exp_dirty;
    logic        exp_victim_valid;
    way_t        exp_hit_way;
    way_t        exp_victim;
    word_t       exp_rdata;
    addr_t       exp_wb_addr;
    logic [31:0] rng_state;

    tb_clkgen u_clkgen (.o_clk(clk), .o_arstn(arstn));

    data_cache UUT (.*);

    // ----------------------------------------
    // Expected outputs from the model.
    // ----------------------------------------
    always_comb begin
        int idx;
        int woff;
        idx         = int'(i_addr[7:4]);
        woff        = int'(i_addr[3:2]);
        exp_hit     = 1'b0;
        exp_hit_way = '0;
        exp_victim  = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == i_addr[31:8]) begin
                exp_hit     = 1'b1;
                exp_hit_way = way_t'(w);
            end
            if (m_age[idx][w] == 0) begin
                exp_victim = way_t'(w);
            end
        end
        exp_rdata = {m_bytes[idx][exp_hit_way][woff*4+3], m_bytes[idx][exp_hit_way][woff*4+2],
                     m_bytes[idx][exp_hit_way][woff*4+1], m_bytes[idx][exp_hit_way][woff*4]};
        case (i_store_size)
            STORE_BYTE: exp_misaligned = 1'b0;
            STORE_HALF: exp_misaligned = i_addr[0];
            default:    exp_misaligned = (i_addr[1:0] != 2'b00);
        endcase
        exp_dirty        = m_dirty[idx][exp_victim];
        exp_victim_valid = m_valid[idx][exp_victim];
        exp_wb_addr      = {m_tag[idx][exp_victim], i_addr[7:4], 4'h0};
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int size_bytes(input store_size_e size);
        case (size)
            STORE_BYTE: return 1;
            STORE_HALF: return 2;
            default:    return 4;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAIL %s got 0x%08h expected 0x%08h at %0t", name, got, want, $time);
        $display("TB FAILED");
        $fatal(1, "Output mismatch.");
    endtask

    task automatic report_stall(input string what);
        $display("Timed out waiting for %s at %0t.", what, $time);
        $display("TB FAILED");
        $fatal(1, "Wait timed out.");
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arstn !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                report_stall("reset release");
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        #2;
    endtask

    // Applies the command held over the last edge to the model.
    task automatic update_model();
        int   idx;
        int   base;
        int   old_age;
        logic hit;
        logic mis;
        way_t hw;
        way_t vw;
        idx  = int'(i_addr[7:4]);
        base = int'(i_addr[3:0]);
        hit  = exp_hit;
        mis  = exp_misaligned;
        hw   = exp_hit_way;
        vw   = exp_victim;
        if (i_refill_en) begin
            m_tag[idx][vw]   = i_addr[31:8];
            m_valid[idx][vw] = 1'b1;
            m_dirty[idx][vw] = 1'b0;
            for (int b = 0; b < LINE_BYTES; b++) begin
                m_bytes[idx][vw][b] = i_refill_line[b*8 +: 8];
            end
        end else if (i_write_en && hit && !mis) begin
            m_dirty[idx][hw] = 1'b1;
            for (int b = 0; b < size_bytes(i_store_size); b++) begin
                m_bytes[idx][hw][base+b] = i_wdata[b*8 +: 8];
            end
        end
        if (i_lru_update && hit) begin
            old_age = m_age[idx][hw];
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == hw) begin
                    m_age[idx][w] = WAYS - 1;
                end else if (m_age[idx][w] > old_age) begin
                    m_age[idx][w] = m_age[idx][w] - 1;
                end
            end
        end
    endtask

    task automatic step_command();
        @(posedge clk);
        #2;
        update_model();
        i_write_en   = 1'b0;
        i_refill_en  = 1'b0;
        i_lru_update = 1'b0;
    endtask

    task automatic probe(input addr_t addr);
        i_addr = addr;
        step_command();
    endtask

    task automatic touch(input addr_t addr);
        i_addr       = addr;
        i_lru_update = 1'b1;
        step_command();
    endtask

    task automatic refill_and_touch(input addr_t addr);
        line_t line;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            line[k*WORD_W +: WORD_W] = next_rand();
        end
        i_addr        = addr;
        i_refill_line = line;
        i_refill_en   = 1'b1;
        step_command();
        touch(addr);
    endtask

    task automatic store_data(input addr_t addr, input word_t data, input store_size_e size);
        i_addr       = addr;
        i_wdata      = data;
        i_store_size = size;
        i_write_en   = 1'b1;
        step_command();
    endtask

    // ----------------------------------------
    // Output checks.
    // ----------------------------------------
    a_hit: assert property (@(posedge clk) disable iff (!arstn) o_hit == exp_hit)
        else report_mismatch("o_hit", 32'($sampled(o_hit)), 32'($sampled(exp_hit)));

    a_rdata: assert property (@(posedge clk) disable iff (!arstn)
        exp_hit |-> o_rdata == exp_rdata)
        else report_mismatch("o_rdata", $sampled(o_rdata), $sampled(exp_rdata));

    a_misaligned: assert property (@(posedge clk) disable iff (!arstn)
        o_misaligned == exp_misaligned)
        else report_mismatch("o_misaligned", 32'($sampled(o_misaligned)),
                             32'($sampled(exp_misaligned)));

    a_dirty: assert property (@(posedge clk) disable iff (!arstn) o_dirty == exp_dirty)
        else report_mismatch("o_dirty", 32'($sampled(o_dirty)), 32'($sampled(exp_dirty)));

    a_wb_addr: assert property (@(posedge clk) disable iff (!arstn)
        exp_victim_valid |-> o_wb_addr == exp_wb_addr)
        else report_mismatch("o_wb_addr", $sampled(o_wb_addr), $sampled(exp_wb_addr));

    // ----------------------------------------
    // Stimulus.
    // ----------------------------------------
    initial begin
        addr_t       base;
        addr_t       addr;
        addr_t       set_addr [8];
        index_t      set_idx;
        logic [31:0] r;
        i_addr        = '0;
        i_wdata       = '0;
        i_store_size  = STORE_WORD;
        i_write_en    = 1'b0;
        i_refill_en   = 1'b0;
        i_refill_line = '0;
        i_lru_update  = 1'b0;
        rng_state     = 32'hfa8;
        for (int s = 0; s < SET_COUNT; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_age[s][w]   = w;
            end
        end
        wait_reset_release();

        // Empty cache misses everywhere.
        repeat (16) begin
            probe(next_rand());
        end

        // Refill, then read every word.
        base = next_rand();
        refill_and_touch(base);
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            probe({base[31:4], 2'(k), 2'b00});
        end

        // Mixed stores, mostly into the refilled line.
        repeat (40) begin
            r    = next_rand();
            addr = (r[3:2] != 2'b00) ? {base[31:4], r[11:8]} : next_rand();
            store_data(addr, next_rand(), store_size_e'(r[1:0] % 2'd3));
            probe({addr[31:2], 2'b00});
        end

        // Fill one set, then reorder by a touch.
        set_idx = base[7:4] + 4'd1;
        for (int k = 0; k < 8; k++) begin
            r           = next_rand();
            set_addr[k] = {r[31:12], 4'(k), set_idx, 4'h0};
        end
        for (int k = 0; k < WAYS; k++) begin
            refill_and_touch(set_addr[k]);
        end
        touch(set_addr[0]);
        probe(set_addr[4]);
        refill_and_touch(set_addr[4]);

        // Dirty lines become victims.
        store_data(set_addr[0], next_rand(), STORE_WORD);
        store_data(set_addr[2], next_rand(), STORE_WORD);
        store_data(set_addr[3], next_rand(), STORE_WORD);
        store_data(set_addr[4], next_rand(), STORE_BYTE);
        for (int k = 5; k < 9; k++) begin
            probe(set_addr[k % 8 == 0 ? 1 : k]);
            refill_and_touch(set_addr[k % 8 == 0 ? 1 : k]);
        end
        for (int k = 0; k < 8; k++) begin
            probe(set_addr[k]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: tb.f
design/cache_geom_pkg.sv
design/cache_op_pkg.sv
design/cache_lookup_if.sv
design/store_align.sv
design/tag_lru_array.sv
design/data_array.sv
design/data_cache.sv
verif/tb_clkgen.sv
verif/tb_data_cache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_data_cache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TB PASSED

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
